// File: mojo_pkg.sv
`default_nettype none

package mojo_pkg;

  localparam int COLOR_W = 3;  // Red, green, blue
  localparam int COORD_W = 10;

  // First byte of every command
  typedef enum logic [7:0] {
    OP_LED  = 8'h01,  // One argument
    OP_FG   = 8'h02,  // Colour in bits 2:0
    OP_BG   = 8'h03,
    OP_RECT = 8'h04   // Four arguments: x0 y0 x1 y1
  } opcode_e;

  typedef enum logic [1:0] {
    ST_OPCODE = 2'd0,
    ST_ARG    = 2'd1,
    ST_SKIP   = 2'd2  // Unknown opcode seen
  } dec_state_e;

endpackage

`default_nettype wire

// File: spi_byte_slave.sv
`timescale 1ns/10ps
`default_nettype none

module spi_byte_slave (
  input  wire        clk,
  input  wire        rst_n,
  input  wire        spi_ss,
  input  wire        spi_sck,
  input  wire        spi_mosi,
  input  wire  [7:0] status,
  output logic       spi_miso,
  output logic [7:0] byte_data,
  output logic       byte_stb,
  output logic       frame_end
);

  logic [2:0] ss_q;
  logic [2:0] sck_q;
  logic [1:0] mosi_q;
  logic [2:0] bit_cnt;
  logic [6:0] rx_shift;
  logic [7:0] tx_shift;
  logic       sck_rise;
  logic       sck_fall;
  logic       ss_rise;

  assign sck_rise = sck_q[1] & ~sck_q[2];
  assign sck_fall = ~sck_q[1] & sck_q[2];
  assign ss_rise  = ss_q[1] & ~ss_q[2];
  assign spi_miso = tx_shift[7];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ss_q   <= 3'b111;
      sck_q  <= 3'b000;
      mosi_q <= 2'b00;
    end else begin
      ss_q   <= {ss_q[1:0], spi_ss};
      sck_q  <= {sck_q[1:0], spi_sck};
      mosi_q <= {mosi_q[0], spi_mosi};
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bit_cnt   <= 3'd0;
      byte_stb  <= 1'b0;
      frame_end <= 1'b0;
    end else begin
      byte_stb  <= 1'b0;
      frame_end <= ss_rise;
      if (ss_q[1]) begin
        bit_cnt <= 3'd0;  // Deselected
      end else if (sck_rise) begin
        bit_cnt  <= bit_cnt + 3'd1;
        byte_stb <= (bit_cnt == 3'd7);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (sck_rise && !ss_q[1]) begin
      rx_shift <= {rx_shift[5:0], mosi_q[1]};
      if (bit_cnt == 3'd7) begin
        byte_data <= {rx_shift, mosi_q[1]};
      end
    end
  end

  // Status reloads at each byte boundary so the MSB is ready before the first rise
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tx_shift <= 8'h00;
    end else if (ss_q[1]) begin
      tx_shift <= status;
    end else if (sck_fall) begin
      if (bit_cnt == 3'd0) begin
        tx_shift <= status;
      end else begin
        tx_shift <= {tx_shift[6:0], 1'b0};
      end
    end
  end

endmodule

`default_nettype wire

// File: cmd_decode.sv
`timescale 1ns/10ps
`default_nettype none

module cmd_decode import mojo_pkg::*; (
  input  wire        clk,
  input  wire        rst_n,
  input  wire  [7:0] byte_data,
  input  wire        byte_stb,
  input  wire        frame_end,
  output logic       wr_stb,
  output opcode_e    wr_sel,
  output logic [1:0] wr_arg_idx,
  output logic [7:0] wr_data,
  output logic       cmd_done
);

  dec_state_e state;
  opcode_e    opcode;
  logic [1:0] arg_idx;
  logic [1:0] last_idx;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= ST_OPCODE;
      opcode   <= OP_LED;
      arg_idx  <= 2'd0;
      last_idx <= 2'd0;
      wr_stb   <= 1'b0;
      cmd_done <= 1'b0;
    end else begin
      wr_stb   <= 1'b0;
      cmd_done <= 1'b0;
      if (frame_end) begin
        state   <= ST_OPCODE;  // Drops a partial command
        arg_idx <= 2'd0;
      end else if (byte_stb) begin
        case (state)
          ST_OPCODE: begin
            arg_idx <= 2'd0;
            case (byte_data)
              OP_LED, OP_FG, OP_BG: begin
                opcode   <= opcode_e'(byte_data);
                last_idx <= 2'd0;
                state    <= ST_ARG;
              end
              OP_RECT: begin
                opcode   <= OP_RECT;
                last_idx <= 2'd3;
                state    <= ST_ARG;
              end
              default: state <= ST_SKIP;
            endcase
          end
          ST_ARG: begin
            wr_stb <= 1'b1;
            if (arg_idx == last_idx) begin
              cmd_done <= 1'b1;
              state    <= ST_OPCODE;
            end else begin
              arg_idx <= arg_idx + 2'd1;
            end
          end
          default: ;  // Skip until ss rises
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (byte_stb && state == ST_ARG) begin
      wr_sel     <= opcode;
      wr_arg_idx <= arg_idx;
      wr_data    <= byte_data;
    end
  end

  // Only the rectangle command carries more than one argument
  a_arg_idx: assert property (@(posedge clk) disable iff (!rst_n)
    wr_stb |-> (wr_sel == OP_RECT || wr_arg_idx == 2'd0))
    else $error("argument index out of range for opcode");

endmodule

`default_nettype wire

// File: draw_regs.sv
`timescale 1ns/10ps
`default_nettype none

module draw_regs import mojo_pkg::*; #(
  parameter int COORD_SHIFT = 2
) (
  input  wire                clk,
  input  wire                rst_n,
  input  wire                wr_stb,
  input  wire  opcode_e      wr_sel,
  input  wire  [1:0]         wr_arg_idx,
  input  wire  [7:0]         wr_data,
  input  wire                cmd_done,
  output logic [7:0]         led,
  output logic [COLOR_W-1:0] fg,
  output logic [COLOR_W-1:0] bg,
  output logic [COORD_W-1:0] rect_x0,
  output logic [COORD_W-1:0] rect_y0,
  output logic [COORD_W-1:0] rect_x1,
  output logic [COORD_W-1:0] rect_y1,
  output logic [7:0]         status
);

  logic [7:0] st_x0;
  logic [7:0] st_y0;
  logic [7:0] st_x1;

  function automatic logic [COORD_W-1:0] scale(input logic [7:0] v);
    return COORD_W'(v) << COORD_SHIFT;
  endfunction

  always_ff @(posedge clk) begin
    if (wr_stb && wr_sel == OP_RECT) begin
      case (wr_arg_idx)
        2'd0: st_x0 <= wr_data;
        2'd1: st_y0 <= wr_data;
        2'd2: st_x1 <= wr_data;
        default: ;  // y1 goes straight to commit
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      led     <= 8'h00;
      fg      <= {COLOR_W{1'b1}};
      bg      <= '0;
      rect_x0 <= COORD_W'(1);  // x0 > x1 means empty
      rect_y0 <= '0;
      rect_x1 <= '0;
      rect_y1 <= '0;
      status  <= 8'h00;
    end else begin
      if (wr_stb) begin
        case (wr_sel)
          OP_LED:  led <= wr_data;
          OP_FG:   fg  <= wr_data[COLOR_W-1:0];
          OP_BG:   bg  <= wr_data[COLOR_W-1:0];
          default: ;
        endcase
      end
      if (cmd_done) begin
        status <= status + 8'd1;  // Wraps at 256
        if (wr_sel == OP_RECT) begin
          rect_x0 <= scale(st_x0);
          rect_y0 <= scale(st_y0);
          rect_x1 <= scale(st_x1);
          rect_y1 <= scale(wr_data);
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: vga_timing.sv
`timescale 1ns/10ps
`default_nettype none

module vga_timing import mojo_pkg::*; #(
  parameter int H_ACTIVE = 640,
  parameter int H_FP     = 16,
  parameter int H_SYNC   = 96,
  parameter int H_BP     = 48,
  parameter int V_ACTIVE = 480,
  parameter int V_FP     = 10,
  parameter int V_SYNC   = 2,
  parameter int V_BP     = 33
) (
  input  wire                clk,
  input  wire                rst_n,
  output logic               hs_raw,
  output logic               vs_raw,
  output logic               active,
  output logic [COORD_W-1:0] px,
  output logic [COORD_W-1:0] py
);

  localparam int H_TOTAL = H_ACTIVE + H_FP + H_SYNC + H_BP;
  localparam int V_TOTAL = V_ACTIVE + V_FP + V_SYNC + V_BP;
  localparam int H_SYNC_START = H_ACTIVE + H_FP;
  localparam int V_SYNC_START = V_ACTIVE + V_FP;
  localparam int HW = $clog2(H_TOTAL);
  localparam int VW = $clog2(V_TOTAL);

  logic [HW-1:0] h_cnt;
  logic [VW-1:0] v_cnt;
  logic          h_last;
  logic          v_last;

  assign h_last = (h_cnt == HW'(H_TOTAL - 1));
  assign v_last = (v_cnt == VW'(V_TOTAL - 1));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (h_last) begin
      h_cnt <= '0;
      v_cnt <= v_last ? '0 : v_cnt + VW'(1);
    end else begin
      h_cnt <= h_cnt + HW'(1);
    end
  end

  // Sync pulses are active low
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      hs_raw <= 1'b1;
      vs_raw <= 1'b1;
      active <= 1'b0;
      px     <= '0;
      py     <= '0;
    end else begin
      hs_raw <= !(h_cnt >= H_SYNC_START && h_cnt < H_SYNC_START + H_SYNC);
      vs_raw <= !(v_cnt >= V_SYNC_START && v_cnt < V_SYNC_START + V_SYNC);
      active <= (h_cnt < H_ACTIVE) && (v_cnt < V_ACTIVE);
      px     <= COORD_W'(h_cnt);
      py     <= COORD_W'(v_cnt);
    end
  end

endmodule

`default_nettype wire

// File: pixel_result.sv
`timescale 1ns/10ps
`default_nettype none

module pixel_result import mojo_pkg::*; (
  input  wire                clk,
  input  wire                rst_n,
  input  wire                hs_raw,
  input  wire                vs_raw,
  input  wire                active,
  input  wire  [COORD_W-1:0] px,
  input  wire  [COORD_W-1:0] py,
  input  wire  [COLOR_W-1:0] fg,
  input  wire  [COLOR_W-1:0] bg,
  input  wire  [COORD_W-1:0] rect_x0,
  input  wire  [COORD_W-1:0] rect_y0,
  input  wire  [COORD_W-1:0] rect_x1,
  input  wire  [COORD_W-1:0] rect_y1,
  output logic               vga_hs,
  output logic               vga_vs,
  output logic               vga_r,
  output logic               vga_g,
  output logic               vga_b
);

  logic               in_rect;
  logic [COLOR_W-1:0] color;

  assign in_rect = (px >= rect_x0) && (px <= rect_x1) &&
                   (py >= rect_y0) && (py <= rect_y1);  // Edges inclusive
  assign color = active ? (in_rect ? fg : bg) : '0;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vga_hs <= 1'b1;
      vga_vs <= 1'b1;
      vga_r  <= 1'b0;
      vga_g  <= 1'b0;
      vga_b  <= 1'b0;
    end else begin
      vga_hs <= hs_raw;  // Same delay as the colour
      vga_vs <= vs_raw;
      vga_r  <= color[2];
      vga_g  <= color[1];
      vga_b  <= color[0];
    end
  end

endmodule

`default_nettype wire

// File: mojo_top.sv
`timescale 1ns/10ps
`default_nettype none

module mojo_top import mojo_pkg::*; #(
  parameter int H_ACTIVE    = 640,
  parameter int H_FP        = 16,
  parameter int H_SYNC      = 96,
  parameter int H_BP        = 48,
  parameter int V_ACTIVE    = 480,
  parameter int V_FP        = 10,
  parameter int V_SYNC      = 2,
  parameter int V_BP        = 33,
  parameter int COORD_SHIFT = 2
) (
  input  wire         clk,
  input  wire         rst_n,
  input  wire         cclk,
  output logic [7:0]  led,
  output logic        spi_miso,
  input  wire         spi_ss,
  input  wire         spi_mosi,
  input  wire         spi_sck,
  output logic [3:0]  spi_channel,
  input  wire         avr_tx,
  output logic        avr_rx,
  input  wire         avr_rx_busy,
  output logic        sdram_clk,
  output logic        sdram_cle,
  output logic        sdram_dqm,
  output logic        sdram_cs,
  output logic        sdram_we,
  output logic        sdram_cas,
  output logic        sdram_ras,
  output logic [1:0]  sdram_ba,
  output logic [12:0] sdram_a,
  inout  wire  [7:0]  sdram_dq,
  output logic        vga_hs,
  output logic        vga_vs,
  output logic        vga_r,
  output logic        vga_g,
  output logic        vga_b
);

  logic [7:0]         byte_data;
  logic               byte_stb;
  logic               frame_end;
  logic               wr_stb;
  opcode_e            wr_sel;
  logic [1:0]         wr_arg_idx;
  logic [7:0]         wr_data;
  logic               cmd_done;
  logic [7:0]         status;
  logic [COLOR_W-1:0] fg;
  logic [COLOR_W-1:0] bg;
  logic [COORD_W-1:0] rect_x0;
  logic [COORD_W-1:0] rect_y0;
  logic [COORD_W-1:0] rect_x1;
  logic [COORD_W-1:0] rect_y1;
  logic               hs_raw;
  logic               vs_raw;
  logic               active;
  logic [COORD_W-1:0] px;
  logic [COORD_W-1:0] py;

  // No ADC, serial link or SDRAM on this build
  assign spi_channel = 4'hf;
  assign avr_rx      = 1'b1;  // Serial idle
  assign sdram_clk   = 1'b0;
  assign sdram_cle   = 1'b0;
  assign sdram_dqm   = 1'b1;
  assign sdram_cs    = 1'b1;  // Deselected
  assign sdram_we    = 1'b1;
  assign sdram_cas   = 1'b1;
  assign sdram_ras   = 1'b1;
  assign sdram_ba    = 2'b00;
  assign sdram_a     = 13'h0000;
  assign sdram_dq    = 8'hzz;

  spi_byte_slave spi_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .spi_ss    (spi_ss),
    .spi_sck   (spi_sck),
    .spi_mosi  (spi_mosi),
    .status    (status),
    .spi_miso  (spi_miso),
    .byte_data (byte_data),
    .byte_stb  (byte_stb),
    .frame_end (frame_end)
  );

  cmd_decode dec_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .byte_data  (byte_data),
    .byte_stb   (byte_stb),
    .frame_end  (frame_end),
    .wr_stb     (wr_stb),
    .wr_sel     (wr_sel),
    .wr_arg_idx (wr_arg_idx),
    .wr_data    (wr_data),
    .cmd_done   (cmd_done)
  );

  draw_regs #(
    .COORD_SHIFT (COORD_SHIFT)
  ) regs_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .wr_stb     (wr_stb),
    .wr_sel     (wr_sel),
    .wr_arg_idx (wr_arg_idx),
    .wr_data    (wr_data),
    .cmd_done   (cmd_done),
    .led        (led),
    .fg         (fg),
    .bg         (bg),
    .rect_x0    (rect_x0),
    .rect_y0    (rect_y0),
    .rect_x1    (rect_x1),
    .rect_y1    (rect_y1),
    .status     (status)
  );

  vga_timing #(
    .H_ACTIVE (H_ACTIVE),
    .H_FP     (H_FP),
    .H_SYNC   (H_SYNC),
    .H_BP     (H_BP),
    .V_ACTIVE (V_ACTIVE),
    .V_FP     (V_FP),
    .V_SYNC   (V_SYNC),
    .V_BP     (V_BP)
  ) timing_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .hs_raw (hs_raw),
    .vs_raw (vs_raw),
    .active (active),
    .px     (px),
    .py     (py)
  );

  pixel_result result_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .hs_raw  (hs_raw),
    .vs_raw  (vs_raw),
    .active  (active),
    .px      (px),
    .py      (py),
    .fg      (fg),
    .bg      (bg),
    .rect_x0 (rect_x0),
    .rect_y0 (rect_y0),
    .rect_x1 (rect_x1),
    .rect_y1 (rect_y1),
    .vga_hs  (vga_hs),
    .vga_vs  (vga_vs),
    .vga_r   (vga_r),
    .vga_g   (vga_g),
    .vga_b   (vga_b)
  );

endmodule

`default_nettype wire

// File: tb_checker.sv
`timescale 1ns/10ps
`default_nettype none

module tb_checker #(
  parameter int H_ACTIVE = 16,
  parameter int H_FP     = 2,
  parameter int H_SYNC   = 3,
  parameter int H_BP     = 3,
  parameter int V_ACTIVE = 8,
  parameter int V_FP     = 1,
  parameter int V_SYNC   = 2,
  parameter int V_BP     = 2
) (
  input  wire        clk,
  input  wire        rst_n,
  input  wire        vga_hs,
  input  wire        vga_vs,
  input  wire        vga_r,
  input  wire        vga_g,
  input  wire        vga_b,
  input  wire [7:0]  led,
  input  wire        spi_ss,
  input  wire        spi_sck,
  input  wire        spi_miso,
  input  wire [3:0]  spi_channel,
  input  wire        avr_rx,
  input  wire        sdram_cs,
  input  wire [20:0] sdram_ctl,
  input  wire        cmd_stb,
  input  wire        exp_stb,
  input  wire [7:0]  exp_led,
  input  wire [2:0]  exp_fg,
  input  wire [2:0]  exp_bg,
  input  wire [9:0]  exp_x0,
  input  wire [9:0]  exp_y0,
  input  wire [9:0]  exp_x1,
  input  wire [9:0]  exp_y1,
  input  wire [7:0]  exp_status,
  output int         pix_errors,
  output int         val_errors
);

  localparam int H_TOTAL = H_ACTIVE + H_FP + H_SYNC + H_BP;
  localparam int V_TOTAL = V_ACTIVE + V_FP + V_SYNC + V_BP;

  logic        hs_prev;
  logic        vs_prev;
  logic        sck_prev;
  logic        h_synced;
  logic        v_synced;
  logic        armed;
  logic        arm_next;
  logic        stat_pending;
  logic [2:0]  fg_q;
  logic [2:0]  bg_q;
  logic [2:0]  rgb;
  logic [2:0]  want;
  logic [7:0]  stat_q;
  logic [7:0]  miso_byte;
  logic [20:0] ctl_q;
  int          h_pos;
  int          v_line;
  int          low_cnt;
  int          miso_bits;
  int          px;
  int          py;
  int          x0;
  int          y0;
  int          x1;
  int          y1;

  always @(negedge clk) begin
    if (!rst_n) begin
      hs_prev      = 1'b1;
      vs_prev      = 1'b1;
      sck_prev     = 1'b0;
      h_synced     = 1'b0;
      v_synced     = 1'b0;
      armed        = 1'b0;
      arm_next     = 1'b0;
      stat_pending = 1'b0;
      ctl_q        = sdram_ctl;  // Idle SDRAM pins never move
      h_pos        = 0;
      v_line       = 0;
      low_cnt      = 0;
      miso_bits    = 0;
      pix_errors   = 0;
      val_errors   = 0;
    end else begin
      if (exp_stb) begin
        if (led !== exp_led) begin
          val_errors++;
          $display("FAIL %0t: led is %02h, expected %02h", $time, led, exp_led);
        end
        if (spi_channel !== 4'hf || avr_rx !== 1'b1) begin
          val_errors++;
          $display("FAIL %0t: spi_channel %h avr_rx %b, expected f and 1",
                   $time, spi_channel, avr_rx);
        end
        if (sdram_cs !== 1'b1 || sdram_ctl !== ctl_q) begin
          val_errors++;
          $display("FAIL %0t: SDRAM pins not idle, cs %b", $time, sdram_cs);
        end
        fg_q         = exp_fg;
        bg_q         = exp_bg;
        x0           = exp_x0;
        y0           = exp_y0;
        x1           = exp_x1;
        y1           = exp_y1;
        stat_q       = exp_status;
        stat_pending = 1'b1;  // Read back during the next byte
        arm_next     = 1'b1;
      end
      if (cmd_stb) begin
        armed    = 1'b0;  // Registers may change mid-frame
        arm_next = 1'b0;
      end

      if (vga_hs && !hs_prev) begin
        if (h_synced && (h_pos != H_TOTAL - 1 || low_cnt != H_SYNC)) begin
          val_errors++;
          $display("FAIL %0t: hsync period %0d low %0d, expected %0d low %0d",
                   $time, h_pos + 1, low_cnt, H_TOTAL, H_SYNC);
        end
        h_synced = 1'b1;
        h_pos    = 0;
        low_cnt  = 0;
        v_line++;
      end else begin
        h_pos++;
        if (!vga_hs) low_cnt++;
      end

      if (vga_vs && !vs_prev) begin
        if (v_synced && v_line != V_TOTAL) begin
          val_errors++;
          $display("FAIL %0t: vsync period %0d lines, expected %0d",
                   $time, v_line, V_TOTAL);
        end
        v_synced = 1'b1;
        v_line   = 0;
        if (arm_next) begin
          armed    = 1'b1;  // Whole frames only
          arm_next = 1'b0;
        end
      end

      if (armed && h_synced && v_synced) begin
        px  = h_pos - H_BP;
        py  = v_line - V_BP;
        rgb = {vga_r, vga_g, vga_b};
        if (px >= 0 && px < H_ACTIVE && py >= 0 && py < V_ACTIVE) begin
          want = (px >= x0 && px <= x1 && py >= y0 && py <= y1) ? fg_q : bg_q;
        end else begin
          want = 3'd0;  // Blanking
        end
        if (rgb !== want) begin
          if (pix_errors < 20) begin
            $display("FAIL %0t: pixel (%0d,%0d) rgb %0d, expected %0d",
                     $time, px, py, rgb, want);
          end
          pix_errors++;
        end
      end

      if (spi_ss) begin
        miso_bits = 0;
      end else if (spi_sck && !sck_prev) begin
        miso_byte = {miso_byte[6:0], spi_miso};  // Mode 0, MSB first
        miso_bits++;
        if (miso_bits == 8) begin
          miso_bits = 0;
          if (stat_pending && miso_byte !== stat_q) begin
            val_errors++;
            $display("FAIL %0t: status on miso %02h, expected %02h",
                     $time, miso_byte, stat_q);
          end
          stat_pending = 1'b0;
        end
      end

      hs_prev  = vga_hs;
      vs_prev  = vga_vs;
      sck_prev = spi_sck;
    end
  end

endmodule

`default_nettype wire

// File: tb_mojo_top.sv
`timescale 1ns/10ps
`default_nettype none

module tb_mojo_top;

  localparam int H_ACTIVE  = 16;
  localparam int H_FP      = 2;
  localparam int H_SYNC    = 3;
  localparam int H_BP      = 3;
  localparam int V_ACTIVE  = 8;
  localparam int V_FP      = 1;
  localparam int V_SYNC    = 2;
  localparam int V_BP      = 2;
  localparam int FRAME_CLK = (H_ACTIVE + H_FP + H_SYNC + H_BP) *
                             (V_ACTIVE + V_FP + V_SYNC + V_BP);
  localparam int HALF_BIT  = 8;  // clk per half SPI bit
  localparam int BYTE_CLK  = 16 * HALF_BIT + 24;
  localparam string STIM_FILE = "mojo_top_stim.txt";

  logic        clk = 1'b0;
  logic        rst_n;
  logic        cclk;
  logic        spi_ss;
  logic        spi_sck;
  logic        spi_mosi;
  logic        avr_tx;
  logic        avr_rx_busy;
  wire  [7:0]  led;
  wire         spi_miso;
  wire  [3:0]  spi_channel;
  wire         avr_rx;
  wire         sdram_clk;
  wire         sdram_cle;
  wire         sdram_dqm;
  wire         sdram_cs;
  wire         sdram_we;
  wire         sdram_cas;
  wire         sdram_ras;
  wire  [1:0]  sdram_ba;
  wire  [12:0] sdram_a;
  wire  [7:0]  sdram_dq;
  wire         vga_hs;
  wire         vga_vs;
  wire         vga_r;
  wire         vga_g;
  wire         vga_b;
  logic        cmd_stb;
  logic        exp_stb;
  logic [7:0]  exp_led;
  logic [2:0]  exp_fg;
  logic [2:0]  exp_bg;
  logic [9:0]  exp_x0;
  logic [9:0]  exp_y0;
  logic [9:0]  exp_x1;
  logic [9:0]  exp_y1;
  logic [7:0]  exp_status;
  int          pix_errors;
  int          val_errors;
  int          cycles = 0;
  int          cycle_limit = 1000000;

  always #10 clk = ~clk;

  mojo_top #(
    .H_ACTIVE (H_ACTIVE), .H_FP (H_FP), .H_SYNC (H_SYNC), .H_BP (H_BP),
    .V_ACTIVE (V_ACTIVE), .V_FP (V_FP), .V_SYNC (V_SYNC), .V_BP (V_BP),
    .COORD_SHIFT (0)
  ) dut_i (
    .clk (clk), .rst_n (rst_n), .cclk (cclk), .led (led),
    .spi_miso (spi_miso), .spi_ss (spi_ss), .spi_mosi (spi_mosi),
    .spi_sck (spi_sck), .spi_channel (spi_channel), .avr_tx (avr_tx),
    .avr_rx (avr_rx), .avr_rx_busy (avr_rx_busy), .sdram_clk (sdram_clk),
    .sdram_cle (sdram_cle), .sdram_dqm (sdram_dqm), .sdram_cs (sdram_cs),
    .sdram_we (sdram_we), .sdram_cas (sdram_cas), .sdram_ras (sdram_ras),
    .sdram_ba (sdram_ba), .sdram_a (sdram_a), .sdram_dq (sdram_dq),
    .vga_hs (vga_hs), .vga_vs (vga_vs), .vga_r (vga_r), .vga_g (vga_g),
    .vga_b (vga_b)
  );

  tb_checker #(
    .H_ACTIVE (H_ACTIVE), .H_FP (H_FP), .H_SYNC (H_SYNC), .H_BP (H_BP),
    .V_ACTIVE (V_ACTIVE), .V_FP (V_FP), .V_SYNC (V_SYNC), .V_BP (V_BP)
  ) chk_i (
    .clk (clk), .rst_n (rst_n), .vga_hs (vga_hs), .vga_vs (vga_vs),
    .vga_r (vga_r), .vga_g (vga_g), .vga_b (vga_b), .led (led),
    .spi_ss (spi_ss), .spi_sck (spi_sck), .spi_miso (spi_miso),
    .spi_channel (spi_channel), .avr_rx (avr_rx), .sdram_cs (sdram_cs),
    .sdram_ctl ({sdram_clk, sdram_cle, sdram_dqm, sdram_we, sdram_cas,
                 sdram_ras, sdram_ba, sdram_a}),
    .cmd_stb (cmd_stb), .exp_stb (exp_stb), .exp_led (exp_led),
    .exp_fg (exp_fg), .exp_bg (exp_bg), .exp_x0 (exp_x0), .exp_y0 (exp_y0),
    .exp_x1 (exp_x1), .exp_y1 (exp_y1), .exp_status (exp_status),
    .pix_errors (pix_errors), .val_errors (val_errors)
  );

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > cycle_limit) begin
      $display("Timeout: stimulus still running after %0d clock cycles", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  task automatic send_byte(input logic [7:0] b);
    int gap;
    gap = 4 + ($urandom % 16);
    @(negedge clk);
    spi_ss  <= 1'b0;
    cmd_stb <= 1'b1;
    @(negedge clk);
    cmd_stb <= 1'b0;
    repeat (gap) @(negedge clk);
    for (int i = 7; i >= 0; i--) begin
      spi_mosi <= b[i];  // Set up while sck is low
      repeat (HALF_BIT) @(negedge clk);
      spi_sck <= 1'b1;
      repeat (HALF_BIT) @(negedge clk);
      spi_sck <= 1'b0;
    end
  endtask

  task automatic end_frame();
    repeat (16) @(negedge clk);
    spi_ss <= 1'b1;
    repeat (8) @(negedge clk);
  endtask

  task automatic wait_frames(input int n);
    repeat (n) @(posedge vga_vs);
    @(negedge clk);
  endtask

  task automatic count_stim(output int n_bytes, output int n_ends, output int n_frames);
    int fd;
    int n;
    int val;
    logic [7:0] kind;
    logic [8*128-1:0] rest;
    n_bytes  = 0;
    n_ends   = 0;
    n_frames = 0;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) return;
    while ($fscanf(fd, " %c", kind) == 1) begin
      case (kind)
        "B": begin
          n = $fscanf(fd, " %h", val);
          n_bytes++;
        end
        "E": n_ends++;
        "W": begin
          n = $fscanf(fd, " %d", val);
          n_frames += val;
        end
        default: n = $fgets(rest, fd);
      endcase
    end
    $fclose(fd);
  endtask

  task automatic run_stim(input int fd);
    int n;
    int val;
    logic [7:0] kind;
    logic [8*128-1:0] rest;
    logic [7:0] e_led;
    logic [2:0] e_fg;
    logic [2:0] e_bg;
    logic [9:0] e_x0;
    logic [9:0] e_y0;
    logic [9:0] e_x1;
    logic [9:0] e_y1;
    logic [7:0] e_st;
    while ($fscanf(fd, " %c", kind) == 1) begin
      case (kind)
        "B": begin
          n = $fscanf(fd, " %h", val);
          send_byte(val[7:0]);
        end
        "E": end_frame();
        "W": begin
          n = $fscanf(fd, " %d", val);
          wait_frames(val);
        end
        "X": begin
          n = $fscanf(fd, " %h %h %h %h %h %h %h %h",
                      e_led, e_fg, e_bg, e_x0, e_y0, e_x1, e_y1, e_st);
          @(negedge clk);
          {exp_led, exp_fg, exp_bg} <= {e_led, e_fg, e_bg};
          {exp_x0, exp_y0, exp_x1, exp_y1} <= {e_x0, e_y0, e_x1, e_y1};
          exp_status <= e_st;
          exp_stb    <= 1'b1;
          @(negedge clk);
          exp_stb <= 1'b0;
        end
        default: n = $fgets(rest, fd);  // Comment line
      endcase
    end
  endtask

  initial begin
    int fd;
    int n_bytes;
    int n_ends;
    int n_frames;
    void'($urandom(78));
    rst_n = 1'b0;
    cclk = 1'b0;
    spi_ss = 1'b1;
    spi_sck = 1'b0;
    spi_mosi = 1'b0;
    avr_tx = 1'b1;
    avr_rx_busy = 1'b0;
    cmd_stb = 1'b0;
    exp_stb = 1'b0;
    {exp_led, exp_fg, exp_bg, exp_status} = '0;
    {exp_x0, exp_y0, exp_x1, exp_y1} = '0;
    count_stim(n_bytes, n_ends, n_frames);
    cycle_limit = 16 + n_bytes * BYTE_CLK + n_ends * 40 + (n_frames + 2) * FRAME_CLK;
    repeat (16) @(negedge clk);
    rst_n <= 1'b1;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      $display("Could not open stimulus file %s", STIM_FILE);
      $display("TEST FAILED");
      $finish;
    end else begin
      run_stim(fd);
      $fclose(fd);
      repeat (4) @(negedge clk);
      $display("Errors: %0d pixel, %0d value", pix_errors, val_errors);
      if (pix_errors + val_errors == 0) begin
        $display("TEST OK");
      end else begin
        $display("TEST FAILED");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: mojo_top_stim.txt
# B hh: send byte (hex) | E: raise spi_ss | W n: wait n video frames
# X led fg bg x0 y0 x1 y1 status: expected values in hex, checked from the next frame
W 2
X 00 7 0 001 000 000 000 00
W 2
B 01
B A5
E
X A5 7 0 001 000 000 000 01
W 2
B 03
B 01
B 02
B 04
B 04
B 03
B 02
B 09
B 05
E
X A5 4 1 003 002 009 005 04
W 2
B 04
B 00
B 00
E
B 7E
B 01
B 55
E
X A5 4 1 003 002 009 005 04
W 2
B 02
B 02
E
X A5 2 1 003 002 009 005 05
W 2
B 00
E

// File: mojo_top.f
mojo_pkg.sv
spi_byte_slave.sv
cmd_decode.sv
draw_regs.sv
vga_timing.sv
pixel_result.sv
mojo_top.sv
tb_checker.sv
tb_mojo_top.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_mojo_top \
  -f mojo_top.f --Mdir obj_dir -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "Verilator build failed, see build.log"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAILED" sim.log; then
  exit 1
fi
if ! grep -q "TEST OK" sim.log; then
  echo "Simulation ended without a pass line"
  exit 1
fi
exit 0
